//--- build.f
verilog/qspi_pkg.sv
verilog/qspi_req_decode.sv
verilog/qspi_write_seq.sv
verilog/qspi_shifter.sv
verilog/qspi_status_check.sv
verilog/qspi_flash_ctrl.sv
testbench/qspi_flash_model.sv
testbench/qspi_flash_ctrl_sva.sv
testbench/tb_qspi_flash_ctrl.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_qspi_flash_ctrl
FILELIST  := build.f

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf obj_dir

//--- testbench/tb_qspi_flash_ctrl.sv
`timescale 1ns/1ns

module tb_qspi_flash_ctrl;

	localparam int MAX_POLLS = 8;
	localparam int N_OPS     = 5;
	localparam int WATCHDOG  = (N_OPS * MAX_POLLS + 4) * 400;

	logic        i_clk = 1'b0;
	logic        i_rst_n, i_wreq, i_ereq, i_pipewr, i_endpipe, i_quad;
	logic [21:0] i_addr;
	logic [31:0] i_data;
	logic [3:0]  i_qspi_dat;
	logic        o_bus_ack, o_wip, o_qspi_sck, o_qspi_cs_n;
	logic [3:0]  o_qspi_dat, o_qspi_dat_oe;
	logic [31:0] word;
	logic        word_tgl, clear_sent;
	logic        tgl_seen = 1'b0;
	int          frames, status_cmds;
	int          ack_cnt = 0;
	int          nibbles = 0;
	int          acks0, frames0, status0, nibbles0;
	logic        failed = 1'b0;
	logic [31:0] got_words[$];
	logic [31:0] exp_words[$];

	always #50 i_clk = ~i_clk;

	qspi_flash_ctrl u_qspi_flash_ctrl (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_wreq(i_wreq), .i_ereq(i_ereq),
		.i_pipewr(i_pipewr), .i_endpipe(i_endpipe), .i_quad(i_quad), .i_addr(i_addr),
		.i_data(i_data), .o_bus_ack(o_bus_ack), .o_wip(o_wip), .o_qspi_sck(o_qspi_sck),
		.o_qspi_cs_n(o_qspi_cs_n), .o_qspi_dat(o_qspi_dat), .o_qspi_dat_oe(o_qspi_dat_oe),
		.i_qspi_dat(i_qspi_dat)
	);

	qspi_flash_model #(.MAX_POLLS(MAX_POLLS)) u_flash (
		.i_sck(o_qspi_sck), .i_cs_n(o_qspi_cs_n), .i_dat(o_qspi_dat),
		.i_dat_oe(o_qspi_dat_oe), .o_dat(i_qspi_dat), .o_word(word), .o_word_tgl(word_tgl),
		.o_frames(frames), .o_status_cmds(status_cmds), .o_clear_sent(clear_sent)
	);

	bind qspi_flash_ctrl qspi_flash_ctrl_sva u_sva (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_bus_ack(o_bus_ack), .i_wip(o_wip),
		.i_cs_n(o_qspi_cs_n), .i_dat_oe(o_qspi_dat_oe)
	);

	// a toggle marks a new word from the flash model.
	always @(negedge i_clk)
		if (word_tgl !== tgl_seen) begin
			tgl_seen <= word_tgl;
			got_words.push_back(word);
		end

	always @(posedge i_clk)
		if (o_bus_ack)
			ack_cnt <= ack_cnt + 1;

	// nibbles the flash sees in quad mode.
	always @(posedge o_qspi_sck)
		if (o_qspi_dat_oe == 4'hf)
			nibbles <= nibbles + 1;

	// ------------------------------------------------------------
	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("MISMATCH time=%0t %s got=%h exp=%h", $time, name, got, exp);
			failed = 1'b1;
			$display("Simulation finished: FAIL");
			$fatal(1);
		end
	endtask

	function automatic logic [31:0] prog_cmd(input logic quad, input logic [21:0] addr);
		return {quad ? 8'h32 : 8'h02, addr, 2'b00};
	endfunction

	function automatic logic [31:0] erase_cmd(input logic [31:0] data);
		return {data[28] ? 8'h20 : 8'hd8, data[21:10], 12'h000};
	endfunction

	task automatic start_op();
		acks0    = ack_cnt;
		frames0  = frames;
		status0  = status_cmds;
		nibbles0 = nibbles;
		got_words.delete();
		exp_words.delete();
	endtask

	task automatic finish_op(input int exp_acks, input int exp_nibbles);
		while (!o_wip)
			@(negedge i_clk);
		while (o_wip)
			@(negedge i_clk);
		check_value("wip_clear_seen", 32'(clear_sent), 32'd1);
		check_value("o_bus_ack count", 32'(ack_cnt - acks0), 32'(exp_acks));
		check_value("cs_n periods", 32'(frames - frames0), 32'd2);
		check_value("read_status cmds", 32'(status_cmds - status0), 32'd1);
		check_value("quad nibbles", 32'(nibbles - nibbles0), 32'(exp_nibbles));
		check_value("word count", 32'(got_words.size()), 32'(exp_words.size()));
		foreach (exp_words[i])
			check_value("flash word", got_words[i], exp_words[i]);
	endtask

	task automatic do_write(input logic quad, input logic [21:0] addr, input logic [31:0] data);
		start_op();
		exp_words = '{prog_cmd(quad, addr), data};
		@(negedge i_clk);
		{i_wreq, i_endpipe, i_quad, i_addr, i_data} = {1'b1, 1'b1, quad, addr, data};
		@(negedge i_clk);
		{i_wreq, i_endpipe} = 2'b00;
		finish_op(1, quad ? 8 : 0);
	endtask

	task automatic do_pipe_write(input logic [21:0] addr, input logic [31:0] data);
		start_op();
		exp_words = '{prog_cmd(1'b0, addr), data, data ^ 32'h1111_1111,
			data ^ 32'h2222_2222, data ^ 32'h3333_3333};
		@(negedge i_clk);
		{i_wreq, i_quad, i_addr, i_data} = {1'b1, 1'b0, addr, data};
		@(negedge i_clk);
		i_wreq = 1'b0;
		for (int i = 0; i < 3; i++) begin
			while (ack_cnt < acks0 + i + 1)
				@(negedge i_clk);
			{i_pipewr, i_endpipe, i_data} = {1'b1, i == 2, exp_words[i + 2]};
			@(negedge i_clk);
			{i_pipewr, i_endpipe} = 2'b00;
		end
		finish_op(4, 0);
	endtask

	task automatic do_erase(input logic [31:0] data);
		start_op();
		exp_words = '{erase_cmd(data)};
		@(negedge i_clk);
		{i_ereq, i_data} = {1'b1, data};
		@(negedge i_clk);
		i_ereq = 1'b0;
		finish_op(1, 0);
	endtask

	// ------------------------------------------------------------
	initial begin
		repeat (WATCHDOG) @(posedge i_clk);
		$display("timeout: an operation did not complete in time");
		$display("Simulation finished: FAIL");
		$fatal(1);
	end

	initial begin
		{i_rst_n, i_wreq, i_ereq, i_pipewr, i_endpipe, i_quad} = 6'b000000;
		i_addr = '0;
		i_data = '0;
		repeat (8) @(negedge i_clk);
		i_rst_n = 1'b1;
		@(negedge i_clk);
		check_value("o_qspi_cs_n", 32'(o_qspi_cs_n), 32'd1);
		check_value("o_wip", 32'(o_wip), 32'd0);
		check_value("o_qspi_dat_oe", 32'(o_qspi_dat_oe), 32'd0);
		do_write(1'b0, 22'h2a_5c31, 32'hdead_beef);
		do_write(1'b1, 22'h01_0f0e, 32'h1234_5678);
		do_pipe_write(22'h3f_0001, 32'hc0de_0a55);
		do_erase(32'h1012_3c00);
		do_erase(32'h0fff_fc00);
		if (!failed) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			$display("Simulation finished: FAIL");
			$fatal(1);
		end
	end

endmodule

//--- testbench/qspi_flash_ctrl_sva.sv
`timescale 1ns/1ns

module qspi_flash_ctrl_sva (
	input logic       i_clk,
	input logic       i_rst_n,
	input logic       i_bus_ack,
	input logic       i_wip,
	input logic       i_cs_n,
	input logic [3:0] i_dat_oe
);

	// chip select is idle when reset lifts.
	cs_high_after_reset: assert property (@(posedge i_clk) $rose(i_rst_n) |-> i_cs_n)
		else $error("chip select low after reset");

	// acks only belong to an operation in flight.
	ack_during_op: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_bus_ack |-> i_wip)
		else $error("bus ack while controller idle");

	pins_idle_cs_high: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_cs_n |-> (i_dat_oe == 4'h0))
		else $error("data pins driven while chip select high");

endmodule

//--- testbench/qspi_flash_model.sv
`timescale 1ns/1ns

module qspi_flash_model #(
	parameter int MAX_POLLS = 8
) (
	input  logic        i_sck,
	input  logic        i_cs_n,
	input  logic [3:0]  i_dat,
	input  logic [3:0]  i_dat_oe,
	output logic [3:0]  o_dat,
	output logic [31:0] o_word,
	output logic        o_word_tgl,
	output int          o_frames,
	output int          o_status_cmds,
	output logic        o_clear_sent
);

	logic [31:0] rng = 32'h8f5a_42cb;
	logic [31:0] acc = '0;
	logic [31:0] word = '0;
	logic        word_tgl = 1'b0;
	logic        status_mode = 1'b0;
	logic        clear_sent = 1'b0;
	logic [3:0]  dat = 4'h0;
	logic [7:0]  byte_val;
	int          frames = 0;
	int          cur_frame = 0;
	int          nbits = 0;
	int          frame_bits = 0;
	int          status_cmds = 0;
	int          polls = 1;
	int          k = 0;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	assign o_dat         = dat;
	assign o_word        = word;
	assign o_word_tgl    = word_tgl;
	assign o_frames      = frames;
	assign o_status_cmds = status_cmds;
	assign o_clear_sent  = clear_sent;

	always @(negedge i_cs_n)
		frames = frames + 1;

	// ------------------------------------------------------------
	// flash samples on the rising sck edge.
	always @(posedge i_sck) begin
		if (frames != cur_frame) begin
			cur_frame   = frames;
			nbits       = 0;
			frame_bits  = 0;
			status_mode = 1'b0;
			k           = 0;
		end
		if (status_mode) begin
			if (i_dat_oe == 4'h0)
				k = k + 1;
		end else if (i_dat_oe != 4'h0) begin
			if (i_dat_oe == 4'hf) begin
				acc        = {acc[27:0], i_dat};
				nbits      = nbits + 4;
				frame_bits = frame_bits + 4;
			end else begin
				acc        = {acc[30:0], i_dat[0]};
				nbits      = nbits + 1;
				frame_bits = frame_bits + 1;
			end
			if (frame_bits == 8 && acc[7:0] == 8'h05) begin
				status_mode = 1'b1;
				status_cmds = status_cmds + 1;
				rng         = xorshift(rng);
				polls       = 1 + int'(rng[15:0]) % MAX_POLLS;
				nbits       = 0;
			end else if (nbits == 32) begin
				word     = acc;
				word_tgl = !word_tgl;
				nbits    = 0;
			end
		end
	end

	// status bytes go out msb first on dat[1], wip set for the first polls bytes.
	always @(negedge i_sck) begin
		if (status_mode) begin
			if (k == 0)
				clear_sent = 1'b0;
			if (k / 8 >= polls)
				clear_sent = 1'b1;
			byte_val = (k / 8 < polls) ? 8'h03 : 8'h02;
			dat = {2'b00, byte_val[7 - k % 8], 1'b0};
		end else begin
			dat = 4'h0;
		end
	end

endmodule

//--- verilog/qspi_flash_ctrl.sv
`timescale 1ns/1ns

module qspi_flash_ctrl (
	input  logic                 i_clk,
	input  logic                 i_rst_n,
	input  logic                 i_wreq,
	input  logic                 i_ereq,
	input  logic                 i_pipewr,
	input  logic                 i_endpipe,
	input  logic                 i_quad,
	input  qspi_pkg::qspi_addr_t i_addr,
	input  qspi_pkg::qspi_word_t i_data,
	output logic                 o_bus_ack,
	output logic                 o_wip,
	output logic                 o_qspi_sck,
	output logic                 o_qspi_cs_n,
	output logic [3:0]           o_qspi_dat,
	output logic [3:0]           o_qspi_dat_oe,
	input  logic [3:0]           i_qspi_dat
);

	logic                 op_valid, op_take, pipe_valid, pipe_end, pipe_take;
	logic                 push, push_quad, push_dir, push_hold;
	logic                 credit, stopped, poll_start, wip_clear, rx_valid;
	qspi_pkg::qspi_op_t   op;
	qspi_pkg::qspi_word_t cmd_word, data_word, push_word;
	qspi_pkg::qspi_len_t  push_len;
	qspi_pkg::qspi_byte_t rx_byte;

	// ------------------------------------------------------------
	qspi_req_decode u_decode (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_wreq(i_wreq), .i_ereq(i_ereq),
		.i_pipewr(i_pipewr), .i_endpipe(i_endpipe), .i_quad(i_quad),
		.i_addr(i_addr), .i_data(i_data), .i_op_take(op_take), .i_pipe_take(pipe_take),
		.o_op_valid(op_valid), .o_op(op), .o_cmd_word(cmd_word), .o_data_word(data_word),
		.o_pipe_valid(pipe_valid), .o_pipe_end(pipe_end), .o_bus_ack(o_bus_ack)
	);

	qspi_write_seq u_seq (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_op_valid(op_valid), .i_op(op),
		.i_cmd_word(cmd_word), .i_data_word(data_word), .i_pipe_valid(pipe_valid),
		.i_pipe_end(pipe_end), .i_credit(credit), .i_stopped(stopped),
		.i_wip_clear(wip_clear), .o_op_take(op_take), .o_pipe_take(pipe_take),
		.o_push(push), .o_push_word(push_word), .o_push_len(push_len),
		.o_push_quad(push_quad), .o_push_dir(push_dir), .o_push_hold(push_hold),
		.o_poll_start(poll_start), .o_wip(o_wip)
	);

	qspi_shifter u_shifter (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_push(push), .i_push_word(push_word),
		.i_push_len(push_len), .i_push_quad(push_quad), .i_push_dir(push_dir),
		.i_push_hold(push_hold), .i_qspi_dat(i_qspi_dat), .o_credit(credit),
		.o_stopped(stopped), .o_rx_valid(rx_valid), .o_rx_byte(rx_byte),
		.o_qspi_sck(o_qspi_sck), .o_qspi_cs_n(o_qspi_cs_n), .o_qspi_dat(o_qspi_dat),
		.o_qspi_dat_oe(o_qspi_dat_oe)
	);

	qspi_status_check u_status (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_poll_start(poll_start),
		.i_rx_valid(rx_valid), .i_rx_byte(rx_byte), .o_wip_clear(wip_clear)
	);

endmodule

//--- verilog/qspi_status_check.sv
`timescale 1ns/1ns

module qspi_status_check (
	input  logic                 i_clk,
	input  logic                 i_rst_n,
	input  logic                 i_poll_start,
	input  logic                 i_rx_valid,
	input  qspi_pkg::qspi_byte_t i_rx_byte,
	output logic                 o_wip_clear
);

	logic active;
	logic skip;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			active      <= 1'b0;
			skip        <= 1'b0;
			o_wip_clear <= 1'b0;
		end else begin
			o_wip_clear <= 1'b0;
			if (i_poll_start) begin
				active <= 1'b1;
				skip   <= 1'b1;
			end else if (active && i_rx_valid) begin
				// first byte of a poll is dropped.
				if (skip) begin
					skip <= 1'b0;
				end else if (!i_rx_byte[0]) begin
					o_wip_clear <= 1'b1;
					active      <= 1'b0;
				end
			end
		end
	end

endmodule

//--- verilog/qspi_shifter.sv
`timescale 1ns/1ns

module qspi_shifter (
	input  logic                 i_clk,
	input  logic                 i_rst_n,
	input  logic                 i_push,
	input  qspi_pkg::qspi_word_t i_push_word,
	input  qspi_pkg::qspi_len_t  i_push_len,
	input  logic                 i_push_quad,
	input  logic                 i_push_dir,
	input  logic                 i_push_hold,
	input  logic [3:0]           i_qspi_dat,
	output logic                 o_credit,
	output logic                 o_stopped,
	output logic                 o_rx_valid,
	output qspi_pkg::qspi_byte_t o_rx_byte,
	output logic                 o_qspi_sck,
	output logic                 o_qspi_cs_n,
	output logic [3:0]           o_qspi_dat,
	output logic [3:0]           o_qspi_dat_oe
);

	// entry layout is {hold, dir, quad, len[1:0], word[31:0]}.
	logic [36:0] fifo_mem [qspi_pkg::QSPI_CREDITS];
	logic [$clog2(qspi_pkg::QSPI_CREDITS)-1:0] wr_ptr, rd_ptr;
	qspi_pkg::qspi_credit_t count;
	qspi_pkg::qspi_word_t   sh_word;
	logic [36:0] push_ent, next_ent, cur_ent;
	logic [4:0]  units;
	logic [2:0]  rx_cnt;
	logic [6:0]  rx_sh;
	logic        busy, avail, word_end, repeat_rd, start, store, pop, rx_take;

	// units per word, less one. bits in single mode, nibbles in quad.
	function automatic logic [4:0] unit_count(input logic quad, input qspi_pkg::qspi_len_t len);
		return quad ? {2'b00, len, 1'b1} : {len, 3'b111};
	endfunction

	assign push_ent  = {i_push_hold, i_push_dir, i_push_quad, i_push_len, i_push_word};
	assign avail     = (count != '0) || i_push;
	assign next_ent  = (count != '0) ? fifo_mem[rd_ptr] : push_ent;
	// sck doubles as the phase of the current unit.
	assign word_end  = busy && o_qspi_sck && (units == 5'd0);
	assign repeat_rd = cur_ent[35] && !cur_ent[36] && i_push_dir && !avail;
	assign start     = avail && (!busy || (word_end && cur_ent[36]));
	assign pop       = start && (count != '0);
	assign store     = i_push && !(start && (count == '0));
	assign rx_take   = busy && o_qspi_sck && cur_ent[35];
	assign o_qspi_dat = cur_ent[34] ? sh_word[31:28] : {3'b000, sh_word[31]};

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			count         <= '0;
			busy          <= 1'b0;
			units         <= '0;
			rx_cnt        <= '0;
			o_credit      <= 1'b0;
			o_stopped     <= 1'b0;
			o_rx_valid    <= 1'b0;
			o_qspi_sck    <= 1'b0;
			o_qspi_cs_n   <= 1'b1;
			o_qspi_dat_oe <= 4'h0;
		end else begin
			o_credit   <= start;
			o_stopped  <= 1'b0;
			o_rx_valid <= rx_take && (rx_cnt == 3'd7);
			if (rx_take)
				rx_cnt <= rx_cnt + 1'b1;
			if (store)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (store && !pop)
				count <= count + 1'b1;
			else if (pop && !store)
				count <= count - 1'b1;
			if (start) begin
				busy          <= 1'b1;
				units         <= unit_count(next_ent[34], next_ent[33:32]);
				o_qspi_sck    <= 1'b0;
				o_qspi_cs_n   <= 1'b0;
				o_qspi_dat_oe <= next_ent[35] ? 4'h0 : (next_ent[34] ? 4'hf : 4'h1);
			end else if (word_end && repeat_rd) begin
				units      <= unit_count(cur_ent[34], cur_ent[33:32]);
				o_qspi_sck <= 1'b0;
			end else if (word_end && cur_ent[36] && i_push_hold) begin
				// hold cs low with the clock stopped until more data.
				busy       <= 1'b0;
				o_qspi_sck <= 1'b0;
			end else if (word_end || (!busy && !o_qspi_cs_n && !i_push_hold)) begin
				busy          <= 1'b0;
				o_qspi_sck    <= 1'b0;
				o_qspi_cs_n   <= 1'b1;
				o_qspi_dat_oe <= 4'h0;
				o_stopped     <= 1'b1;
			end else if (busy) begin
				o_qspi_sck <= !o_qspi_sck;
				if (o_qspi_sck)
					units <= units - 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (store)
			fifo_mem[wr_ptr] <= push_ent;
		if (start) begin
			cur_ent <= next_ent;
			sh_word <= next_ent[31:0];
		end else if (word_end && repeat_rd) begin
			sh_word <= cur_ent[31:0];
		end else if (busy && o_qspi_sck && !word_end) begin
			sh_word <= cur_ent[34] ? {sh_word[27:0], 4'h0} : {sh_word[30:0], 1'b0};
		end
		// status data comes back on dat[1], sampled while sck is high.
		if (rx_take) begin
			rx_sh <= {rx_sh[5:0], i_qspi_dat[1]};
			if (rx_cnt == 3'd7)
				o_rx_byte <= {rx_sh, i_qspi_dat[1]};
		end
	end

endmodule

//--- verilog/qspi_write_seq.sv
`timescale 1ns/1ns

module qspi_write_seq (
	input  logic                 i_clk,
	input  logic                 i_rst_n,
	input  logic                 i_op_valid,
	input  qspi_pkg::qspi_op_t   i_op,
	input  qspi_pkg::qspi_word_t i_cmd_word,
	input  qspi_pkg::qspi_word_t i_data_word,
	input  logic                 i_pipe_valid,
	input  logic                 i_pipe_end,
	input  logic                 i_credit,
	input  logic                 i_stopped,
	input  logic                 i_wip_clear,
	output logic                 o_op_take,
	output logic                 o_pipe_take,
	output logic                 o_push,
	output qspi_pkg::qspi_word_t o_push_word,
	output qspi_pkg::qspi_len_t  o_push_len,
	output logic                 o_push_quad,
	output logic                 o_push_dir,
	output logic                 o_push_hold,
	output logic                 o_poll_start,
	output logic                 o_wip
);

	qspi_pkg::wr_state_t    state;
	qspi_pkg::qspi_credit_t credits;
	logic                   want;
	logic                   rd_sent;

	// a word leaves only while a buffer slot is known free.
	assign o_push       = want && (credits != '0);
	assign o_op_take    = o_push && (state == qspi_pkg::wr_program || state == qspi_pkg::wr_erase);
	assign o_pipe_take  = o_push && (state == qspi_pkg::wr_getnext);
	assign o_poll_start = o_push && (state == qspi_pkg::wr_status_read);
	assign o_wip        = (state != qspi_pkg::wr_idle);

	// ------------------------------------------------------------
	// push word selection. hold also tells the shifter to keep cs low.
	always_comb begin
		want        = 1'b0;
		o_push_word = i_data_word;
		o_push_len  = 2'b11;
		o_push_quad = 1'b0;
		o_push_dir  = 1'b0;
		o_push_hold = 1'b0;
		case (state)
		qspi_pkg::wr_cmd: begin
			want        = 1'b1;
			o_push_word = i_cmd_word;
			o_push_hold = 1'b1;
		end
		qspi_pkg::wr_program: begin
			want        = 1'b1;
			o_push_quad = (i_op == qspi_pkg::op_qwrite);
			o_push_hold = 1'b1;
		end
		qspi_pkg::wr_getnext: begin
			want        = i_pipe_valid;
			o_push_quad = (i_op == qspi_pkg::op_qwrite);
			o_push_hold = 1'b1;
		end
		qspi_pkg::wr_erase: begin
			want        = 1'b1;
			o_push_word = i_cmd_word;
		end
		qspi_pkg::wr_status_cmd: begin
			want        = 1'b1;
			o_push_word = {qspi_pkg::OP_READ_STATUS, 24'h000000};
			o_push_len  = 2'b00;
			o_push_hold = 1'b1;
		end
		qspi_pkg::wr_status_read: begin
			// dir stays high to keep the status read repeating.
			want        = !rd_sent;
			o_push_word = '0;
			o_push_len  = 2'b00;
			o_push_dir  = 1'b1;
		end
		default: begin
		end
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state   <= qspi_pkg::wr_idle;
			credits <= qspi_pkg::qspi_credit_t'(qspi_pkg::QSPI_CREDITS);
			rd_sent <= 1'b0;
		end else begin
			if (o_push && !i_credit)
				credits <= credits - 1'b1;
			else if (!o_push && i_credit)
				credits <= credits + 1'b1;
			case (state)
			qspi_pkg::wr_idle:
				if (i_op_valid)
					state <= (i_op == qspi_pkg::op_erase) ? qspi_pkg::wr_erase : qspi_pkg::wr_cmd;
			qspi_pkg::wr_cmd:
				if (o_push)
					state <= qspi_pkg::wr_program;
			qspi_pkg::wr_program:
				if (o_push)
					state <= qspi_pkg::wr_getnext;
			qspi_pkg::wr_getnext:
				if (!i_pipe_valid && i_pipe_end)
					state <= qspi_pkg::wr_wait_stop;
			qspi_pkg::wr_erase:
				if (o_push)
					state <= qspi_pkg::wr_wait_stop;
			qspi_pkg::wr_wait_stop:
				if (i_stopped)
					state <= qspi_pkg::wr_status_cmd;
			qspi_pkg::wr_status_cmd: begin
				rd_sent <= 1'b0;
				if (o_push)
					state <= qspi_pkg::wr_status_read;
			end
			qspi_pkg::wr_status_read: begin
				if (o_push)
					rd_sent <= 1'b1;
				if (i_wip_clear)
					state <= qspi_pkg::wr_final_stop;
			end
			qspi_pkg::wr_final_stop:
				if (i_stopped)
					state <= qspi_pkg::wr_idle;
			default:
				state <= qspi_pkg::wr_idle;
			endcase
		end
	end

endmodule

//--- verilog/qspi_req_decode.sv
`timescale 1ns/1ns

module qspi_req_decode (
	input  logic                 i_clk,
	input  logic                 i_rst_n,
	input  logic                 i_wreq,
	input  logic                 i_ereq,
	input  logic                 i_pipewr,
	input  logic                 i_endpipe,
	input  logic                 i_quad,
	input  qspi_pkg::qspi_addr_t i_addr,
	input  qspi_pkg::qspi_word_t i_data,
	input  logic                 i_op_take,
	input  logic                 i_pipe_take,
	output logic                 o_op_valid,
	output qspi_pkg::qspi_op_t   o_op,
	output qspi_pkg::qspi_word_t o_cmd_word,
	output qspi_pkg::qspi_word_t o_data_word,
	output logic                 o_pipe_valid,
	output logic                 o_pipe_end,
	output logic                 o_bus_ack
);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_op_valid   <= 1'b0;
			o_op         <= qspi_pkg::op_write;
			o_pipe_valid <= 1'b0;
			o_pipe_end   <= 1'b0;
			o_bus_ack    <= 1'b0;
		end else begin
			// bus ack trails each take by one cycle.
			o_bus_ack <= i_op_take || i_pipe_take;
			if (i_wreq) begin
				o_op_valid <= 1'b1;
				o_op       <= i_quad ? qspi_pkg::op_qwrite : qspi_pkg::op_write;
			end else if (i_ereq) begin
				o_op_valid <= 1'b1;
				o_op       <= qspi_pkg::op_erase;
			end else if (i_op_take) begin
				o_op_valid <= 1'b0;
			end
			if (i_pipewr)
				o_pipe_valid <= 1'b1;
			else if (i_pipe_take)
				o_pipe_valid <= 1'b0;
			// end of pipe may come with the request itself.
			if (i_endpipe)
				o_pipe_end <= 1'b1;
			else if (i_wreq || i_ereq)
				o_pipe_end <= 1'b0;
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_wreq)
			o_cmd_word <= {i_quad ? qspi_pkg::OP_QPROGRAM : qspi_pkg::OP_PROGRAM, i_addr, 2'b00};
		else if (i_ereq)
			o_cmd_word <= {i_data[28] ? qspi_pkg::OP_SECTOR_ERASE : qspi_pkg::OP_BLOCK_ERASE,
				i_data[21:10], 12'h000};
		if (i_wreq || i_pipewr)
			o_data_word <= i_data;
	end

endmodule

//--- verilog/qspi_pkg.sv
package qspi_pkg;

	// ------------------------------------------------------------
	// flash opcodes.
	localparam logic [7:0] OP_PROGRAM      = 8'h02;
	localparam logic [7:0] OP_QPROGRAM     = 8'h32;
	localparam logic [7:0] OP_SECTOR_ERASE = 8'h20;
	localparam logic [7:0] OP_BLOCK_ERASE  = 8'hd8;
	localparam logic [7:0] OP_READ_STATUS  = 8'h05;

	// shifter buffer depth and the sequencer's starting credit.
	localparam int unsigned QSPI_CREDITS = 2;

	// ------------------------------------------------------------
	typedef logic [31:0] qspi_word_t;
	typedef logic [21:0] qspi_addr_t;
	// bytes to shift, minus one.
	typedef logic [1:0]  qspi_len_t;
	typedef logic [7:0]  qspi_byte_t;
	typedef logic [$clog2(QSPI_CREDITS + 1)-1:0] qspi_credit_t;

	typedef enum logic [1:0] {op_write, op_qwrite, op_erase} qspi_op_t;

	typedef enum logic [3:0] {
		wr_idle,
		wr_cmd,
		wr_program,
		wr_getnext,
		wr_erase,
		wr_wait_stop,
		wr_status_cmd,
		wr_status_read,
		wr_final_stop
	} wr_state_t;

endpackage
